// ==== hw/tcb_lite_pkg.sv ====
////////////////////////////////////////////////////////////
// TCB-Lite shared definitions
// bus widths, response delay
// legal byte-enable pattern check
////////////////////////////////////////////////////////////

`default_nettype none

package tcb_lite_pkg;

    // data bus width and byte lanes
    localparam int unsigned DAT_W = 32;
    localparam int unsigned BYT_W = DAT_W / 8;

    // byte address width
    localparam int unsigned ADR_W = 32;

    // response delay after the transfer edge
    localparam int unsigned DLY = 1;

    ////////////////////////////////////////////////////////////
    // byte enable legality
    ////////////////////////////////////////////////////////////

    // legal means one naturally aligned power of two run of lanes
    // single byte, aligned halfword or the full word
    function automatic logic byt_legal(input logic [BYT_W-1:0] byt);
        logic [BYT_W-1:0] pat;
        int unsigned      sz;
        byt_legal = 1'b0;
        for (int unsigned k = 0; k <= $clog2(BYT_W); k++) begin
            sz = 1 << k;
            // walk aligned offsets for this size
            for (int unsigned off = 0; off < BYT_W; off += sz) begin
                pat = ({BYT_W{1'b1}} >> (BYT_W - sz)) << off;
                if (byt == pat) byt_legal = 1'b1;
            end
        end
        // zero never matches a pattern above
    endfunction

endpackage

`default_nettype wire

// ==== hw/tcb_lite_dec.sv ====
////////////////////////////////////////////////////////////
// TCB-Lite address decoder
// steers vld to one subordinate, flags unmapped addresses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_lite_dec #(
    // number of subordinates, power of two
    parameter int unsigned SUB_N  = 4,
    // word address width of one subordinate
    parameter int unsigned SUB_AW = 6
)(
    // request from the manager
    input  logic                           vld,
    input  logic [tcb_lite_pkg::ADR_W-1:0] adr,
    // back to the manager
    output logic                           rdy,
    // per subordinate valid
    output logic [SUB_N-1:0]               sub_vld,
    // towards the response mux
    output logic [$clog2(SUB_N)-1:0]       sel,
    output logic                           unm
);

    ////////////////////////////////////////////////////////////
    // address fields
    ////////////////////////////////////////////////////////////

    // byte offset bits inside a word
    localparam int unsigned OFF_W = $clog2(tcb_lite_pkg::BYT_W);
    // subordinate index width
    localparam int unsigned SEL_W = $clog2(SUB_N);
    // first bit of the subordinate index
    localparam int unsigned SEL_LSB = OFF_W + SUB_AW;
    // first bit above the mapped range
    localparam int unsigned HI_LSB = SEL_LSB + SEL_W;

    // subordinate index straight from the address
    assign sel = adr[SEL_LSB +: SEL_W];

    // any high bit set means no subordinate owns it
    assign unm = |adr[tcb_lite_pkg::ADR_W-1:HI_LSB];

    ////////////////////////////////////////////////////////////
    // handshake and steering
    ////////////////////////////////////////////////////////////

    // no subordinate stalls
    // unmapped requests are accepted as well so the manager never hangs
    assign rdy = 1'b1;

    // one hot valid, none for unmapped
    always_comb begin
        sub_vld = '0;
        if (vld && !unm) begin
            sub_vld[sel] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tcb_lite_mem.sv ====
////////////////////////////////////////////////////////////
// TCB-Lite memory subordinate
// byte enabled storage, registered response
// error flag for illegal byte enable patterns
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_lite_mem #(
    // word address width
    parameter int unsigned SUB_AW = 6
)(
    // system
    input  logic                           tcb,
    input  logic                           rst_n,
    // request
    input  logic                           vld,
    input  logic                           wen,
    input  logic [SUB_AW-1:0]              idx,
    input  logic [tcb_lite_pkg::BYT_W-1:0] byt,
    input  logic [tcb_lite_pkg::DAT_W-1:0] wdt,
    // response
    output logic [tcb_lite_pkg::DAT_W-1:0] rdt,
    output logic                           err
);

    // word count
    localparam int unsigned DEPTH = 2**SUB_AW;

    // storage, no reset
    logic [tcb_lite_pkg::DAT_W-1:0] mem [DEPTH];

    // byte enable check result
    logic legal;

    // byt expanded to a bit mask
    logic [tcb_lite_pkg::DAT_W-1:0] msk;

    ////////////////////////////////////////////////////////////
    // byte enable decode
    ////////////////////////////////////////////////////////////

    assign legal = tcb_lite_pkg::byt_legal(byt);

    always_comb begin
        for (int unsigned b = 0; b < tcb_lite_pkg::BYT_W; b++) begin
            msk[8*b +: 8] = {8{byt[b]}};
        end
    end

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    // only enabled lanes change
    // illegal pattern leaves the word untouched
    always_ff @(posedge tcb) begin
        if (vld && wen && legal) begin
            for (int unsigned b = 0; b < tcb_lite_pkg::BYT_W; b++) begin
                if (byt[b]) begin
                    mem[idx][8*b +: 8] <= wdt[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    // registered on the transfer edge, valid one cycle later
    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            rdt <= '0;
            err <= 1'b0;
        end else if (vld) begin
            // illegal pattern reported for reads and writes
            err <= !legal;
            // read data only for a legal read, disabled lanes zero
            if (!wen && legal) begin
                rdt <= mem[idx] & msk;
            end else begin
                rdt <= '0;
            end
        end else begin
            // idle cycle holds zero
            rdt <= '0;
            err <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tcb_lite_rsp_mux.sv ====
////////////////////////////////////////////////////////////
// TCB-Lite response mux
// delays the selection, merges read data and error
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_lite_rsp_mux #(
    // number of subordinates
    parameter int unsigned SUB_N = 4
)(
    // system
    input  logic                                 tcb,
    input  logic                                 rst_n,
    // transfer cycle info from the decoder
    input  logic                                 trn,
    input  logic [$clog2(SUB_N)-1:0]             sel,
    input  logic                                 unm,
    // flat subordinate responses
    input  logic [SUB_N*tcb_lite_pkg::DAT_W-1:0] sub_rdt,
    input  logic [SUB_N-1:0]                     sub_err,
    // to the manager
    output logic [tcb_lite_pkg::DAT_W-1:0]       rdt,
    output logic                                 err
);

    localparam int unsigned DLY = tcb_lite_pkg::DLY;

    // delay line, last stage marks the response cycle
    logic [DLY-1:0]                    trn_dly;
    logic [DLY-1:0][$clog2(SUB_N)-1:0] sel_dly;
    logic [DLY-1:0]                    unm_dly;

    // transfer strobe pipe
    always_ff @(posedge tcb) begin
        if (!rst_n) begin
            trn_dly <= '0;
        end else begin
            trn_dly[0] <= trn;
            for (int unsigned i = 1; i < DLY; i++) begin
                trn_dly[i] <= trn_dly[i-1];
            end
        end
    end

    // selection captured only on the transfer edge
    always_ff @(posedge tcb) begin
        if (trn) begin
            sel_dly[0] <= sel;
            unm_dly[0] <= unm;
        end
        for (int unsigned i = 1; i < DLY; i++) begin
            sel_dly[i] <= sel_dly[i-1];
            unm_dly[i] <= unm_dly[i-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // output select
    ////////////////////////////////////////////////////////////

    // zero outside the response cycle
    always_comb begin
        rdt = '0;
        err = 1'b0;
        if (trn_dly[DLY-1]) begin
            if (unm_dly[DLY-1]) begin
                // nobody answered, rdt stays zero
                err = 1'b1;
            end else begin
                rdt = sub_rdt[sel_dly[DLY-1]*tcb_lite_pkg::DAT_W +: tcb_lite_pkg::DAT_W];
                err = sub_err[sel_dly[DLY-1]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/tcb_sys.sv ====
////////////////////////////////////////////////////////////
// TCB-Lite memory subsystem top level
// decoder, SUB_N memory subordinates, response mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_sys #(
    // number of subordinates, power of two
    parameter int unsigned SUB_N  = 4,
    // word address width per subordinate
    parameter int unsigned SUB_AW = 6
)(
    // system
    input  logic                           tcb,
    input  logic                           rst_n,
    // request from the manager
    input  logic                           vld,
    input  logic                           wen,
    input  logic [tcb_lite_pkg::ADR_W-1:0] adr,
    input  logic [tcb_lite_pkg::BYT_W-1:0] byt,
    input  logic [tcb_lite_pkg::DAT_W-1:0] wdt,
    // response to the manager
    output logic                           rdy,
    output logic [tcb_lite_pkg::DAT_W-1:0] rdt,
    output logic                           err
);

    // byte offset width, word index starts above it
    localparam int unsigned OFF_W = $clog2(tcb_lite_pkg::BYT_W);

    // decoder outputs
    logic [SUB_N-1:0]         sub_vld;
    logic [$clog2(SUB_N)-1:0] sel;
    logic                     unm;

    // transfer strobe
    logic trn;

    // flat subordinate responses
    logic [SUB_N*tcb_lite_pkg::DAT_W-1:0] sub_rdt;
    logic [SUB_N-1:0]                     sub_err;

    assign trn = vld & rdy;

    ////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////

    tcb_lite_dec #(
        .SUB_N   (SUB_N),
        .SUB_AW  (SUB_AW)
    ) u_dec (
        .vld     (vld),
        .adr     (adr),
        .rdy     (rdy),
        .sub_vld (sub_vld),
        .sel     (sel),
        .unm     (unm)
    );

    // one memory per subordinate slot
    // shared request fields, private vld and response slice
    for (genvar g = 0; g < SUB_N; g++) begin : g_sub
        tcb_lite_mem #(
            .SUB_AW (SUB_AW)
        ) u_mem (
            .tcb    (tcb),
            .rst_n  (rst_n),
            .vld    (sub_vld[g]),
            .wen    (wen),
            .idx    (adr[OFF_W +: SUB_AW]),
            .byt    (byt),
            .wdt    (wdt),
            .rdt    (sub_rdt[g*tcb_lite_pkg::DAT_W +: tcb_lite_pkg::DAT_W]),
            .err    (sub_err[g])
        );
    end

    ////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////

    tcb_lite_rsp_mux #(
        .SUB_N   (SUB_N)
    ) u_rsp_mux (
        .tcb     (tcb),
        .rst_n   (rst_n),
        .trn     (trn),
        .sel     (sel),
        .unm     (unm),
        .sub_rdt (sub_rdt),
        .sub_err (sub_err),
        .rdt     (rdt),
        .err     (err)
    );

endmodule

`default_nettype wire

// ==== verif/tcb_clk_gen.sv ====
////////////////////////////////////////////////////////////
// testbench clock and synchronous reset source
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_clk_gen #(
    parameter int unsigned PERIOD_NS = 20,
    parameter int unsigned RST_CYC   = 16
)(
    output logic tcb,
    output logic rst_n
);

    initial begin
        tcb = 1'b0;
        forever #(PERIOD_NS / 2) tcb = ~tcb;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYC) @(posedge tcb);
        @(negedge tcb);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tcb_lite_checker_sva.sv ====
////////////////////////////////////////////////////////////
// TCB-Lite protocol assertions
// bound into tcb_sys
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_lite_checker_sva (
    input logic                           tcb,
    input logic                           rst_n,
    input logic                           vld,
    input logic                           rdy,
    input logic                           wen,
    input logic [tcb_lite_pkg::ADR_W-1:0] adr,
    input logic [tcb_lite_pkg::BYT_W-1:0] byt,
    input logic [tcb_lite_pkg::DAT_W-1:0] wdt,
    input logic [tcb_lite_pkg::DAT_W-1:0] rdt,
    input logic                           err
);

    // failure tally, read by the testbench
    int unsigned fail_cnt = 0;

    // write data with disabled lanes forced to zero
    logic [tcb_lite_pkg::DAT_W-1:0] wdt_msk;

    always_comb begin
        for (int unsigned b = 0; b < tcb_lite_pkg::BYT_W; b++) begin
            wdt_msk[8*b +: 8] = wdt[8*b +: 8] & {8{byt[b]}};
        end
    end

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    a_vld_known: assert property (@(posedge tcb) !$isunknown(vld))
        else begin $error("vld unknown"); fail_cnt++; end

    a_vld_rst: assert property (@(posedge tcb) !rst_n |-> !vld)
        else begin $error("vld high during reset"); fail_cnt++; end

    // first edge after reset release
    a_vld_post_rst: assert property (@(posedge tcb) $rose(rst_n) |-> !vld)
        else begin $error("vld high right after reset"); fail_cnt++; end

    a_req_known: assert property (@(posedge tcb) disable iff (!rst_n)
        (vld && rdy) |-> !$isunknown({wen, adr, byt, wdt_msk}))
        else begin $error("request field unknown in transfer"); fail_cnt++; end

    ////////////////////////////////////////////////////////////
    // response side, one cycle after a read
    ////////////////////////////////////////////////////////////

    a_rsp_known: assert property (@(posedge tcb) disable iff (!rst_n)
        (vld && rdy && !wen) |=> !$isunknown({rdt, err}))
        else begin $error("read response unknown"); fail_cnt++; end

endmodule

bind tcb_sys tcb_lite_checker_sva u_chk (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (vld),
    .rdy   (rdy),
    .wen   (wen),
    .adr   (adr),
    .byt   (byt),
    .wdt   (wdt),
    .rdt   (rdt),
    .err   (err)
);

`default_nettype wire

// ==== verif/tcb_sys_tb.sv ====
////////////////////////////////////////////////////////////
// testbench for tcb_sys
// stimulus, reference model, compare process, watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_sys_tb;

    localparam int unsigned SUB_N   = 4;
    localparam int unsigned SUB_AW  = 6;
    localparam int unsigned MAP_W   = SUB_AW + $clog2(SUB_N);
    localparam int unsigned N_WORDS = 1 << MAP_W;
    localparam int unsigned N_MIX   = 8;
    localparam int unsigned N_ILL   = 9;
    localparam int unsigned N_RND   = 400;
    localparam logic [3:0]  ILL_PAT [N_ILL] = '{4'h0, 4'h5, 4'h6, 4'h7, 4'h9,
                                                4'hA, 4'hB, 4'hD, 4'hE};
    // full writes and reads, mixed, illegal, unmapped, random
    localparam int unsigned N_XFER  = 2*N_WORDS + 4*N_MIX + 3*N_ILL + 4 + N_RND;
    localparam int unsigned WDOG_NS = N_XFER*40 + 16*20 + 2000;

    logic        tcb, rst_n, vld, wen, rdy, err;
    logic [31:0] adr, wdt, rdt, a, r;
    logic [3:0]  byt;

    logic [31:0] shadow [N_WORDS];
    logic [32:0] exp_q [$];
    logic [31:0] rnd_st = 32'h5a76_b315;
    logic        pend = 1'b0;
    int unsigned val_errs = 0;
    int unsigned other_errs = 0;

    tcb_clk_gen #(.PERIOD_NS(20), .RST_CYC(16)) u_clk (.tcb(tcb), .rst_n(rst_n));

    tcb_sys #(.SUB_N(SUB_N), .SUB_AW(SUB_AW)) UUT (
        .tcb(tcb), .rst_n(rst_n), .vld(vld), .wen(wen), .adr(adr),
        .byt(byt), .wdt(wdt), .rdy(rdy), .rdt(rdt), .err(err)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // expected {err, rdt}, shadow memory updated on writes
    function automatic logic [32:0] ref_model(input logic w, input logic [31:0] ad,
                                              input logic [3:0] b, input logic [31:0] d);
        logic [31:0]      m;
        logic             ok;
        logic [MAP_W-1:0] wi;
        // anything above the map is unmapped
        if (ad[31:MAP_W+2] != '0) return {1'b1, 32'h0};
        case (b)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111: ok = 1'b1;
            default: ok = 1'b0;
        endcase
        if (!ok) return {1'b1, 32'h0};
        wi = ad[MAP_W+1:2];
        m  = {{8{b[3]}}, {8{b[2]}}, {8{b[1]}}, {8{b[0]}}};
        if (w) begin
            shadow[wi] = (shadow[wi] & ~m) | (d & m);
            return {1'b0, 32'h0};
        end
        return {1'b0, shadow[wi] & m};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
            val_errs++;
        end
    endtask

    // one request per falling edge, expected value queued
    task automatic xfer(input logic w, input logic [31:0] ad,
                        input logic [3:0] b, input logic [31:0] d);
        @(negedge tcb);
        vld = 1'b1;
        wen = w;
        adr = ad;
        byt = b;
        wdt = d;
        exp_q.push_back(ref_model(w, ad, b, d));
    endtask

    task automatic go_idle();
        @(negedge tcb);
        vld = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////

    always @(posedge tcb) pend <= rst_n && vld && rdy;

    // mid cycle sample, response registered on the transfer edge
    always @(negedge tcb) begin : cmp
        logic [32:0] e;
        if (rst_n && pend) begin
            if (exp_q.size() == 0) begin
                $display("response cycle with no expected value queued at %0t", $time);
                other_errs++;
            end else begin
                e = exp_q.pop_front();
                check("rdt", rdt, e[31:0]);
                check("err", {31'b0, err}, {31'b0, e[32]});
            end
        end else if (rst_n) begin
            // idle response fields hold zero
            check("rdt", rdt, 32'h0);
            check("err", {31'b0, err}, 32'h0);
        end
    end

    initial begin : watchdog
        #(WDOG_NS);
        $display("timeout after %0d ns, stimulus did not finish", WDOG_NS);
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        vld = 1'b0;
        wen = 1'b0;
        adr = '0;
        byt = '0;
        wdt = '0;
        // vld stays low one edge past reset
        @(posedge rst_n);
        @(posedge tcb);
        @(negedge tcb);
        check("rdy", {31'b0, rdy}, 32'h1);
        check("rdt", rdt, 32'h0);
        check("err", {31'b0, err}, 32'h0);
        // full words everywhere, then read back
        for (int unsigned i = 0; i < N_WORDS; i++) begin
            rnd_st = xorshift(rnd_st);
            xfer(1'b1, i << 2, 4'hF, rnd_st);
        end
        for (int unsigned i = 0; i < N_WORDS; i++) xfer(1'b0, i << 2, 4'hF, 32'h0);
        // byte and halfword merges, partial reads
        for (int unsigned i = 0; i < N_MIX; i++) begin
            a = (i * 33) << 2;
            rnd_st = xorshift(rnd_st);
            xfer(1'b1, a, 4'b0001 << (i % 4), rnd_st);
            rnd_st = xorshift(rnd_st);
            xfer(1'b1, a, i[0] ? 4'b1100 : 4'b0011, rnd_st);
            xfer(1'b0, a, 4'hF, 32'h0);
            xfer(1'b0, a, 4'b0001 << ((i + 1) % 4), 32'h0);
        end
        // illegal enables, full read shows the word untouched
        for (int unsigned j = 0; j < N_ILL; j++) begin
            a = (j * 29 + 3) << 2;
            rnd_st = xorshift(rnd_st);
            xfer(1'b1, a, ILL_PAT[j], rnd_st);
            xfer(1'b0, a, ILL_PAT[j], 32'h0);
            xfer(1'b0, a, 4'hF, 32'h0);
        end
        // first bit above the map and the top bit
        xfer(1'b1, 32'h0000_0400, 4'hF, 32'hdead_beef);
        xfer(1'b0, 32'h0000_0400, 4'hF, 32'h0);
        xfer(1'b1, 32'h8000_0000, 4'hF, 32'h1234_5678);
        xfer(1'b0, 32'h8000_0000, 4'hF, 32'h0);
        // back to back random, low address bits random too
        for (int unsigned k = 0; k < N_RND; k++) begin
            rnd_st = xorshift(rnd_st);
            r = rnd_st;
            a = {22'h0, r[17:8]};
            if (r[23:20] == 4'h0) a[31:10] = {r[31:24], 14'h0001};
            rnd_st = xorshift(rnd_st);
            xfer(r[0], a, r[7:4], rnd_st);
        end
        go_idle();
        while (exp_q.size() != 0) @(negedge tcb);
        repeat (2) @(negedge tcb);
        // leave the last compare edge behind
        @(posedge tcb);
        $display("summary: %0d value errors, %0d sequencing errors, %0d assertion failures",
                 val_errs, other_errs, UUT.u_chk.fail_cnt);
        if (val_errs == 0 && other_errs == 0 && UUT.u_chk.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/tcb_lite_pkg.sv
hw/tcb_lite_dec.sv
hw/tcb_lite_mem.sv
hw/tcb_lite_rsp_mux.sv
hw/tcb_sys.sv
verif/tcb_clk_gen.sv
verif/tcb_lite_checker_sva.sv
verif/tcb_sys_tb.sv

// ==== Makefile ====
# Verilator build and run for the TCB-Lite memory subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tcb_sys_tb
FLIST     := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# assertion failures are counted, so the run continues past them
run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+1000 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
